// ==== source/audio_pkg.sv ====
package audio_pkg;

   // ----------------------------------------------------------
   // Widths
   // ----------------------------------------------------------
   localparam int SAMPLE_W   = 8;
   localparam int APB_ADDR_W = 8;
   localparam int APB_DATA_W = 8;

   // Unsigned voice sample
   typedef logic [SAMPLE_W-1:0] sample_t;

   // Bit 0 routes to left, bit 1 routes to right
   typedef logic [1:0] pan_t;

   localparam pan_t PAN_RESET = 2'b11;

   // ----------------------------------------------------------
   // APB bus
   // ----------------------------------------------------------
   typedef struct packed {
      logic                  psel;
      logic                  penable;
      logic                  pwrite;
      logic [APB_ADDR_W-1:0] paddr;
      logic [APB_DATA_W-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [APB_DATA_W-1:0] prdata;
      logic                  pready;
      logic                  pslverr;
   } apb_rsp_t;

   // One voice after panning
   typedef struct packed {
      sample_t left;
      sample_t right;
   } panned_t;

   // ----------------------------------------------------------
   // Register map
   // ----------------------------------------------------------
   localparam logic [APB_ADDR_W-1:0] ADDR_PAN_BASE = 8'h00;
   localparam logic [APB_ADDR_W-1:0] ADDR_CTRL     = 8'h10;

endpackage

// ==== source/audio_regs.sv ====
`timescale 1ns/100ps

module audio_regs #(
   parameter int NUM_VOICES = 4
) (
   input  logic                                clk28,
   input  logic                                rst_n,
   input  audio_pkg::apb_req_t                 apb_req,
   output audio_pkg::apb_rsp_t                 apb_rsp,
   output audio_pkg::pan_t [NUM_VOICES-1:0]    pan,
   output logic [1:0]                          mute
);

   localparam int IDX_W = (NUM_VOICES > 1) ? $clog2(NUM_VOICES) : 1;

   logic [audio_pkg::APB_ADDR_W-1:0] pan_offset;
   logic [IDX_W-1:0]                 pan_idx;
   logic                             pan_hit;
   logic                             ctrl_hit;
   logic                             access;
   logic                             wr_en;

   // ----------------------------------------------------------
   // Address decode
   // ----------------------------------------------------------

   // Wraps to a large value below the base, so one compare covers both ends
   assign pan_offset = apb_req.paddr - audio_pkg::ADDR_PAN_BASE;
   assign pan_idx    = pan_offset[IDX_W-1:0];
   assign pan_hit    = (pan_offset < audio_pkg::APB_ADDR_W'(NUM_VOICES));
   assign ctrl_hit   = (apb_req.paddr == audio_pkg::ADDR_CTRL);

   // Access phase of a transfer
   assign access = apb_req.psel & apb_req.penable;
   assign wr_en  = access & apb_req.pwrite;

   // ----------------------------------------------------------
   // Register storage
   // ----------------------------------------------------------
   always_ff @(posedge clk28 or negedge rst_n) begin
      if (!rst_n) begin
         pan  <= {NUM_VOICES{audio_pkg::PAN_RESET}};
         mute <= 2'b00;
      end else if (wr_en) begin
         if (pan_hit) begin
            pan[pan_idx] <= apb_req.pwdata[1:0];
         end else if (ctrl_hit) begin
            mute <= apb_req.pwdata[1:0];
         end
      end
   end

   // ----------------------------------------------------------
   // Read data and response
   // ----------------------------------------------------------
   always_comb begin
      apb_rsp        = '0;
      apb_rsp.pready = 1'b1;

      // Upper data bits stay zero for every register
      if (pan_hit) begin
         apb_rsp.prdata[1:0] = pan[pan_idx];
      end else if (ctrl_hit) begin
         apb_rsp.prdata[1:0] = mute;
      end

      // Unmapped address flagged only in the access cycle
      apb_rsp.pslverr = access & ~(pan_hit | ctrl_hit);
   end

endmodule

// ==== source/voice_panner.sv ====
`timescale 1ns/100ps

module voice_panner (
   input  logic                clk28,
   input  logic                rst_n,
   input  audio_pkg::sample_t  sample,
   input  audio_pkg::pan_t     pan,
   output audio_pkg::panned_t  panned
);

   audio_pkg::panned_t panned_d;

   // Gate the sample onto each side by its pan bit
   always_comb begin
      panned_d       = '0;
      if (pan[0]) begin
         panned_d.left = sample;
      end
      if (pan[1]) begin
         panned_d.right = sample;
      end
   end

   // One cycle from sample or pan change
   always_ff @(posedge clk28 or negedge rst_n) begin
      if (!rst_n) begin
         panned <= '0;
      end else begin
         panned <= panned_d;
      end
   end

endmodule

// ==== source/stereo_dac.sv ====
`timescale 1ns/100ps

module stereo_dac #(
   parameter int NUM_VOICES = 4
) (
   input  logic                                  clk28,
   input  logic                                  rst_n,
   input  audio_pkg::panned_t [NUM_VOICES-1:0]   panned,
   input  logic [1:0]                            mute,
   output logic                                  audio_left,
   output logic                                  audio_right
);

   // Wide enough for NUM_VOICES full scale samples
   localparam int SUM_W = audio_pkg::SAMPLE_W + $clog2(NUM_VOICES);

   // Index 0 is left, index 1 is right, matching the mute bits
   logic [1:0][SUM_W-1:0] sum_d;
   logic [1:0][SUM_W-1:0] sum_q;
   logic [1:0][SUM_W-1:0] acc;
   logic [1:0]            dac_bit;

   // ----------------------------------------------------------
   // Channel sums
   // ----------------------------------------------------------
   always_comb begin
      sum_d = '0;
      for (int v = 0; v < NUM_VOICES; v++) begin
         sum_d[0] = sum_d[0] + SUM_W'(panned[v].left);
         sum_d[1] = sum_d[1] + SUM_W'(panned[v].right);
      end
   end

   // ----------------------------------------------------------
   // Registered sums and first-order delta-sigma modulators
   // ----------------------------------------------------------
   always_ff @(posedge clk28 or negedge rst_n) begin
      if (!rst_n) begin
         sum_q   <= '0;
         acc     <= '0;
         dac_bit <= 2'b00;
      end else begin
         for (int ch = 0; ch < 2; ch++) begin
            // Muted channel feeds zero into its modulator
            sum_q[ch] <= mute[ch] ? '0 : sum_d[ch];

            // Carry out of the accumulator is the output bit
            {dac_bit[ch], acc[ch]} <= {1'b0, acc[ch]} + (SUM_W + 1)'(sum_q[ch]);
         end
      end
   end

   assign audio_left  = dac_bit[0];
   assign audio_right = dac_bit[1];

endmodule

// ==== source/zx_audio_mixer.sv ====
`timescale 1ns/100ps

module zx_audio_mixer #(
   parameter int NUM_VOICES = 4
) (
   input  logic                                  clk28,
   input  logic                                  rst_n,
   input  audio_pkg::apb_req_t                   apb_req,
   output audio_pkg::apb_rsp_t                   apb_rsp,
   input  audio_pkg::sample_t [NUM_VOICES-1:0]   voices,
   output logic                                  audio_left,
   output logic                                  audio_right
);

   audio_pkg::pan_t    [NUM_VOICES-1:0] pan;
   audio_pkg::panned_t [NUM_VOICES-1:0] panned;
   logic [1:0]                          mute;

   // ----------------------------------------------------------
   // Pan and mute registers
   // ----------------------------------------------------------
   audio_regs #(
      .NUM_VOICES (NUM_VOICES)
   ) audio_regs_i (
      .clk28   (clk28),
      .rst_n   (rst_n),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .pan     (pan),
      .mute    (mute)
   );

   // ----------------------------------------------------------
   // One panner per voice
   // ----------------------------------------------------------
   for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
      voice_panner voice_panner_i (
         .clk28  (clk28),
         .rst_n  (rst_n),
         .sample (voices[v]),
         .pan    (pan[v]),
         .panned (panned[v])
      );
   end

   // Mixer and 1-bit DACs
   stereo_dac #(
      .NUM_VOICES (NUM_VOICES)
   ) stereo_dac_i (
      .clk28       (clk28),
      .rst_n       (rst_n),
      .panned      (panned),
      .mute        (mute),
      .audio_left  (audio_left),
      .audio_right (audio_right)
   );

endmodule

// ==== dv/clk_rst_gen.sv ====
`timescale 1ns/100ps

module clk_rst_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 2
) (
   output logic clk28,
   output logic rst_n
);

   initial begin
      clk28 = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk28 = ~clk28;
      end
   end

   // Held low over RESET_CYCLES rising edges, released on a falling edge
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk28);
      @(negedge clk28);
      rst_n = 1'b1;
   end

endmodule

// ==== dv/tb_zx_audio_mixer.sv ====
`timescale 1ns/100ps

module tb_zx_audio_mixer;

   localparam int NUM_VOICES    = 4;
   localparam int SETTLE_CYCLES = 8;
   localparam int WINDOW        = 1024;
   localparam int RESET_TIMEOUT = 20;
   localparam int APB_TIMEOUT   = 16;
   localparam int RANDOM_ROWS   = 6;

   typedef struct {
      string                                name;
      audio_pkg::sample_t [NUM_VOICES-1:0]  smp;
      audio_pkg::pan_t    [NUM_VOICES-1:0]  pan;
      logic [1:0]                           mute;
      int                                   exp_left;
      int                                   exp_right;
   } row_t;

   logic                                 clk28;
   logic                                 rst_n;
   audio_pkg::apb_req_t                  apb_req;
   audio_pkg::apb_rsp_t                  apb_rsp;
   audio_pkg::sample_t [NUM_VOICES-1:0]  voices;
   logic                                 audio_left;
   logic                                 audio_right;

   row_t        rows[$];
   logic [31:0] rng_state;
   int          errors;
   int          checks_run;
   int          tests_run;
   int          tests_failed;

   clk_rst_gen #(
      .PERIOD_NS    (40),
      .RESET_CYCLES (2)
   ) clk_rst_gen_i (
      .clk28 (clk28),
      .rst_n (rst_n)
   );

   zx_audio_mixer #(
      .NUM_VOICES (NUM_VOICES)
   ) zx_audio_mixer_i (
      .clk28       (clk28),
      .rst_n       (rst_n),
      .apb_req     (apb_req),
      .apb_rsp     (apb_rsp),
      .voices      (voices),
      .audio_left  (audio_left),
      .audio_right (audio_right)
   );

   // ----------------------------------------------------------
   // Checking and reporting
   // ----------------------------------------------------------
   task automatic check_value(input string signal, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks_run++;
      if (expected !== actual) begin
         $display("[ERROR] %0t ns %s expected %0d actual %0d", $time, signal, expected, actual);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int errors_at_start);
      tests_run++;
      if (errors == errors_at_start) begin
         $display("test %-24s ok", name);
      end else begin
         tests_failed++;
         $display("test %-24s failed with %0d errors", name, errors - errors_at_start);
      end
   endtask

   task automatic abort_on_timeout(input string what);
      $display("Timeout: %s at %0t ns", what, $time);
      $display("SIMULATION FAILED");
      $finish;
   endtask

   // Ones expected on one channel for a row
   function automatic int expected_ones(input row_t row, input int ch);
      int total;
      total = 0;
      for (int v = 0; v < NUM_VOICES; v++) begin
         if (row.pan[v][ch]) begin
            total += row.smp[v];
         end
      end
      return row.mute[ch] ? 0 : total;
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // ----------------------------------------------------------
   // APB and DAC helpers
   // ----------------------------------------------------------
   task automatic wait_for_reset();
      int waited;
      waited = 0;
      while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
         @(posedge clk28);
         waited++;
      end
      if (rst_n !== 1'b1) begin
         abort_on_timeout("reset was never released");
      end
   endtask

   task automatic apb_transfer(input logic write, input logic [7:0] addr,
                               input logic [7:0] wdata, output logic [7:0] rdata,
                               output logic err);
      int waited;
      waited = 0;
      @(negedge clk28);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(negedge clk28);
      apb_req.penable = 1'b1;
      // Response taken at the edge that closes the access cycle
      @(posedge clk28);
      while (apb_rsp.pready !== 1'b1 && waited < APB_TIMEOUT) begin
         @(posedge clk28);
         waited++;
      end
      if (apb_rsp.pready !== 1'b1) begin
         abort_on_timeout("APB slave never raised pready");
      end else begin
         rdata = apb_rsp.prdata;
         err   = apb_rsp.pslverr;
         @(negedge clk28);
         apb_req.psel    = 1'b0;
         apb_req.penable = 1'b0;
         apb_req.pwrite  = 1'b0;
      end
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data, input logic exp_err);
      logic [7:0] rdata;
      logic       err;
      apb_transfer(1'b1, addr, data, rdata, err);
      check_value($sformatf("pslverr wr 0x%02h", addr), exp_err, err);
   endtask

   task automatic read_reg(input logic [7:0] addr, input int exp_data, input logic exp_err);
      logic [7:0] rdata;
      logic       err;
      apb_transfer(1'b0, addr, 8'h00, rdata, err);
      check_value($sformatf("prdata 0x%02h", addr), exp_data, rdata);
      check_value($sformatf("pslverr rd 0x%02h", addr), exp_err, err);
   endtask

   task automatic count_ones(output integer left_ones, output integer right_ones);
      left_ones  = 0;
      right_ones = 0;
      repeat (WINDOW) begin
         @(negedge clk28);
         left_ones  += audio_left;
         right_ones += audio_right;
      end
   endtask

   // ----------------------------------------------------------
   // Stimulus table
   // ----------------------------------------------------------
   task automatic add_row(input string name, input audio_pkg::sample_t [NUM_VOICES-1:0] smp,
                          input audio_pkg::pan_t [NUM_VOICES-1:0] pan, input logic [1:0] mute,
                          input int exp_left, input int exp_right);
      row_t row;
      row.name      = name;
      row.smp       = smp;
      row.pan       = pan;
      row.mute      = mute;
      row.exp_left  = exp_left;
      row.exp_right = exp_right;
      rows.push_back(row);
   endtask

   task automatic load_table();
      row_t row;
      // Voice 3 first in each concatenation
      add_row("left only", {8'd40, 8'd30, 8'd20, 8'd10}, {4{2'd1}}, 2'b00, 100, 0);
      add_row("right only", {8'd40, 8'd30, 8'd20, 8'd10}, {4{2'd2}}, 2'b00, 0, 100);
      add_row("mixed routing", {8'd40, 8'd30, 8'd20, 8'd10},
              {2'd3, 2'd2, 2'd1, 2'd0}, 2'b00, 60, 70);
      add_row("both channels", {8'd5, 8'd25, 8'd50, 8'd100}, {4{2'd3}}, 2'b00, 180, 180);
      add_row("mute left", {8'd5, 8'd25, 8'd50, 8'd100}, {4{2'd3}}, 2'b01, 0, 180);
      add_row("mute right", {8'd5, 8'd25, 8'd50, 8'd100}, {4{2'd3}}, 2'b10, 180, 0);
      add_row("mute both", {8'd5, 8'd25, 8'd50, 8'd100}, {4{2'd3}}, 2'b11, 0, 0);
      add_row("full scale", {4{8'd255}}, {4{2'd3}}, 2'b00, 1020, 1020);
      add_row("uneven routing", {8'd129, 8'd77, 8'd13, 8'd200},
              {2'd0, 2'd3, 2'd2, 2'd1}, 2'b00, 277, 90);
      add_row("all off", {8'd4, 8'd3, 8'd2, 8'd1}, {4{2'd0}}, 2'b00, 0, 0);

      for (int i = 0; i < RANDOM_ROWS; i++) begin
         rng_state = xorshift32(rng_state);
         row.smp   = rng_state;
         rng_state = xorshift32(rng_state);
         row.pan   = rng_state[7:0];
         row.mute  = 2'b00;
         add_row($sformatf("random row %0d", i), row.smp, row.pan, row.mute,
                 expected_ones(row, 0), expected_ones(row, 1));
      end
   endtask

   // ----------------------------------------------------------
   // Tests
   // ----------------------------------------------------------
   task automatic reset_state_test();
      int     start;
      integer left_ones;
      integer right_ones;
      start = errors;
      check_value("audio_left", 0, audio_left);
      check_value("audio_right", 0, audio_right);
      // Every pan register comes up routed to both channels
      for (int v = 0; v < NUM_VOICES; v++) begin
         read_reg(8'(audio_pkg::ADDR_PAN_BASE + v), 3, 1'b0);
      end
      read_reg(audio_pkg::ADDR_CTRL, 0, 1'b0);
      count_ones(left_ones, right_ones);
      check_value("audio_left ones", 0, left_ones);
      check_value("audio_right ones", 0, right_ones);
      report_test("reset state", start);
   endtask

   task automatic register_access_test();
      int start;
      start = errors;
      // Upper data bits are set and must read back as zero
      for (int v = 0; v < NUM_VOICES; v++) begin
         write_reg(8'(audio_pkg::ADDR_PAN_BASE + v), 8'hFC | 8'((v + 1) % 4), 1'b0);
      end
      write_reg(audio_pkg::ADDR_CTRL, 8'hFE, 1'b0);
      for (int v = 0; v < NUM_VOICES; v++) begin
         read_reg(8'(audio_pkg::ADDR_PAN_BASE + v), (v + 1) % 4, 1'b0);
      end
      read_reg(audio_pkg::ADDR_CTRL, 2, 1'b0);

      // Unmapped address
      write_reg(8'h08, 8'hFF, 1'b1);
      read_reg(8'h08, 0, 1'b1);
      for (int v = 0; v < NUM_VOICES; v++) begin
         read_reg(8'(audio_pkg::ADDR_PAN_BASE + v), (v + 1) % 4, 1'b0);
      end
      read_reg(audio_pkg::ADDR_CTRL, 2, 1'b0);
      write_reg(audio_pkg::ADDR_CTRL, 8'h00, 1'b0);
      report_test("register access", start);
   endtask

   task automatic run_row(input row_t row);
      int     start;
      integer left_ones;
      integer right_ones;
      start = errors;
      for (int v = 0; v < NUM_VOICES; v++) begin
         write_reg(8'(audio_pkg::ADDR_PAN_BASE + v), 8'(row.pan[v]), 1'b0);
      end
      write_reg(audio_pkg::ADDR_CTRL, 8'(row.mute), 1'b0);
      @(negedge clk28);
      voices = row.smp;
      repeat (SETTLE_CYCLES) @(negedge clk28);
      count_ones(left_ones, right_ones);
      check_value("audio_left ones", row.exp_left, left_ones);
      check_value("audio_right ones", row.exp_right, right_ones);
      report_test(row.name, start);
   endtask

   initial begin
      apb_req      = '0;
      voices       = '0;
      rng_state    = 32'd43851;
      errors       = 0;
      checks_run   = 0;
      tests_run    = 0;
      tests_failed = 0;
      load_table();
      wait_for_reset();
      reset_state_test();
      register_access_test();
      foreach (rows[i]) begin
         run_row(rows[i]);
      end
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks_run, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== zx_audio_mixer.f ====
source/audio_pkg.sv
source/audio_regs.sv
source/voice_panner.sv
source/stereo_dac.sv
source/zx_audio_mixer.sv
dv/clk_rst_gen.sv
dv/tb_zx_audio_mixer.sv

// ==== Bender.yml ====
package:
  name: zx_audio_mixer

sources:
  # RTL in compile order
  - files:
      - source/audio_pkg.sv
      - source/audio_regs.sv
      - source/voice_panner.sv
      - source/stereo_dac.sv
      - source/zx_audio_mixer.sv

  # Testbench
  - target: test
    files:
      - dv/clk_rst_gen.sv
      - dv/tb_zx_audio_mixer.sv

dependencies: {}
